// File: include/layers_cfg.svh
`ifndef LAYERS_CFG_SVH
`define LAYERS_CFG_SVH

// datapath sizes
`define LAYERS_DEPTH_NB     4
`define LAYERS_GROUP_NB     2
`define LAYERS_IMG_WIDTH    16
`define LAYERS_KER_WIDTH    16
// wide enough for one product plus headroom
`define LAYERS_NUM_WIDTH    (`LAYERS_IMG_WIDTH + `LAYERS_KER_WIDTH + 1)

// configuration bus and layer register layout
`define LAYERS_CFG_AWIDTH   5
`define LAYERS_CFG_DWIDTH   32
`define LAYERS_CFG_ADDR     2
`define LAYERS_BYPASS_BIT   16
`define LAYERS_POOL_MSB     15
`define LAYERS_POOL_LSB     8
`define LAYERS_SHIFT_MSB    7
`define LAYERS_SHIFT_LSB    0

// pipeline depths in cycles
`define LAYERS_MAC_LATENCY  3
`define LAYERS_POOL_LATENCY 1
`define LAYERS_OPS_LATENCY  3

`endif

// File: src/layers_pkg.sv
`include "layers_cfg.svh"

package layers_pkg;

    typedef logic signed [`LAYERS_IMG_WIDTH-1:0] pixel_t;
    typedef logic signed [`LAYERS_KER_WIDTH-1:0] ker_t;
    typedef logic signed [`LAYERS_NUM_WIDTH-1:0] num_t;

    // the last flag marks the end of a frame
    typedef struct packed {
        pixel_t [`LAYERS_GROUP_NB-1:0] pix;
        logic                          last;
    } image_beat_t;

    typedef ker_t [`LAYERS_GROUP_NB-1:0] kernel_lane_t;
    typedef kernel_lane_t [`LAYERS_DEPTH_NB-1:0] kernel_bus_t;
    typedef ker_t [`LAYERS_DEPTH_NB-1:0] bias_bus_t;
    typedef pixel_t [`LAYERS_DEPTH_NB-1:0] result_t;

    typedef struct packed {
        logic                          valid;
        logic [`LAYERS_CFG_AWIDTH-1:0] addr;
        logic [`LAYERS_CFG_DWIDTH-1:0] data;
    } cfg_write_t;

    typedef struct packed {
        logic                                        bypass;
        logic [`LAYERS_POOL_MSB-`LAYERS_POOL_LSB:0]   pool_nb;
        logic [`LAYERS_SHIFT_MSB-`LAYERS_SHIFT_LSB:0] shift;
    } layer_cfg_t;

    // strobes shared by every lane
    typedef struct packed {
        logic acc_clear;
        logic acc_en;
        logic hold_en;
        logic pool_restart;
        logic pool_en;
        logic ops_en;
        logic result_load;
    } lane_ctrl_t;

endpackage

// File: src/layer_cfg_regs.sv
`timescale 1ns/1ns

`include "layers_cfg.svh"

module layer_cfg_regs
    import layers_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cfg_write_t cfg,
    output layer_cfg_t layer_cfg
);

    logic hit;

    // only the layer register lives at this address
    assign hit = cfg.valid && (cfg.addr == `LAYERS_CFG_AWIDTH'(`LAYERS_CFG_ADDR));

    always_ff @(posedge clk) begin
        if (rst) begin
            layer_cfg <= '0;
        end else if (hit) begin
            layer_cfg.bypass  <= cfg.data[`LAYERS_BYPASS_BIT];
            layer_cfg.pool_nb <= cfg.data[`LAYERS_POOL_MSB:`LAYERS_POOL_LSB];
            layer_cfg.shift   <= cfg.data[`LAYERS_SHIFT_MSB:`LAYERS_SHIFT_LSB];
        end
    end

endmodule

// File: src/conv_lane.sv
`timescale 1ns/1ns

`include "layers_cfg.svh"

module conv_lane
    import layers_pkg::*;
(
    input  logic         clk,
    input  lane_ctrl_t   lane_ctrl,
    input  image_beat_t  pixels,
    input  kernel_lane_t kernels,
    output num_t         frame_sum
);

    localparam int GROUP_NB = `LAYERS_GROUP_NB;

    pixel_t [GROUP_NB-1:0] pix_q;
    num_t   [GROUP_NB-1:0] prod_q;
    num_t   [GROUP_NB-1:0] acc_q;
    num_t                  group_sum;
    num_t                  hold_q;

    // beat lines up with the kernels that follow it one cycle later
    always_ff @(posedge clk) begin
        pix_q <= pixels.pix;
    end

    // products are sign extended to the accumulator width
    always_ff @(posedge clk) begin
        for (int g = 0; g < GROUP_NB; g++) begin
            prod_q[g] <= pix_q[g] * kernels[g];
        end
    end

    // one accumulator per group
    always_ff @(posedge clk) begin
        for (int g = 0; g < GROUP_NB; g++) begin
            if (lane_ctrl.acc_clear) begin
                acc_q[g] <= '0;
            end else if (lane_ctrl.acc_en) begin
                acc_q[g] <= acc_q[g] + prod_q[g];
            end
        end
    end

    always_comb begin
        group_sum = '0;
        for (int g = 0; g < GROUP_NB; g++) begin
            group_sum = group_sum + acc_q[g];
        end
    end

    // frees the accumulators for the next frame
    always_ff @(posedge clk) begin
        if (lane_ctrl.hold_en) begin
            hold_q <= group_sum;
        end
    end

    assign frame_sum = hold_q;

endmodule

// File: src/post_ops_lane.sv
`timescale 1ns/1ns

`include "layers_cfg.svh"

module post_ops_lane
    import layers_pkg::*;
(
    input  logic       clk,
    input  lane_ctrl_t lane_ctrl,
    input  layer_cfg_t layer_cfg,
    input  num_t       frame_sum,
    input  ker_t       bias,
    output pixel_t     result
);

    localparam pixel_t PIX_MAX = {1'b0, {(`LAYERS_IMG_WIDTH-1){1'b1}}};
    localparam pixel_t PIX_MIN = {1'b1, {(`LAYERS_IMG_WIDTH-1){1'b0}}};

    num_t   max_q;
    num_t   biased_q;
    num_t   relu_q;
    num_t   shifted;
    pixel_t scaled_q;
    pixel_t result_q;

    // running max over the pooling window
    always_ff @(posedge clk) begin
        if (lane_ctrl.pool_en) begin
            if (lane_ctrl.pool_restart || (frame_sum > max_q)) begin
                max_q <= frame_sum;
            end
        end
    end

    // bias is sign extended to the accumulator width
    always_ff @(posedge clk) begin
        if (lane_ctrl.ops_en) begin
            biased_q <= max_q + num_t'(bias);
        end
    end

    always_ff @(posedge clk) begin
        if (lane_ctrl.ops_en) begin
            if ((biased_q < 0) && !layer_cfg.bypass) begin
                relu_q <= '0;
            end else begin
                relu_q <= biased_q;
            end
        end
    end

    // rounds toward minus infinity
    assign shifted = relu_q >>> layer_cfg.shift;

    always_ff @(posedge clk) begin
        if (lane_ctrl.ops_en) begin
            if (shifted > PIX_MAX) begin
                scaled_q <= PIX_MAX;
            end else if (shifted < PIX_MIN) begin
                scaled_q <= PIX_MIN;
            end else begin
                scaled_q <= pixel_t'(shifted);
            end
        end
    end

    // result stays put while the port is stalled
    always_ff @(posedge clk) begin
        if (lane_ctrl.result_load) begin
            result_q <= scaled_q;
        end
    end

    assign result = result_q;

endmodule

// File: src/layers_ctrl.sv
`timescale 1ns/1ns

`include "layers_cfg.svh"

module layers_ctrl
    import layers_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  layer_cfg_t layer_cfg,
    input  logic       image_val,
    input  logic       image_last,
    output logic       image_rdy,
    output logic       kernel_rdy,
    output logic       result_val,
    input  logic       result_rdy,
    output lane_ctrl_t lane_ctrl
);

    localparam int UP_RESET = 0;
    localparam int UP_READY = 1;
    localparam int UP_DONE  = 2;
    localparam int UP_CLEAR = 3;

    localparam int DN_RESET = 0;
    localparam int DN_READY = 1;
    localparam int DN_ADD   = 2;
    localparam int DN_POOL  = 3;
    localparam int DN_OPS   = 4;
    localparam int DN_CLEAR = 5;

    localparam int MAC_LAT = `LAYERS_MAC_LATENCY;
    localparam int OPS_LAT = `LAYERS_POOL_LATENCY + `LAYERS_OPS_LATENCY;

    logic [3:0]                               up_state;
    logic [3:0]                               up_state_nx;
    logic [5:0]                               dn_state;
    logic [5:0]                               dn_state_nx;
    logic                                     image_acc;
    logic                                     pool_full;
    logic                                     prod_val;
    logic [MAC_LAT-1:0]                       mac_chain;
    logic [OPS_LAT-1:0]                       ops_chain;
    logic [`LAYERS_POOL_MSB-`LAYERS_POOL_LSB:0] pool_cnt;

    assign image_acc = image_val & image_rdy;
    assign pool_full = (pool_cnt >= layer_cfg.pool_nb);

    always_ff @(posedge clk) begin
        if (rst) begin
            up_state <= 4'b1 << UP_RESET;
            dn_state <= 6'b1 << DN_RESET;
        end else begin
            up_state <= up_state_nx;
            dn_state <= dn_state_nx;
        end
    end

    // accumulation side
    always_comb begin
        up_state_nx = '0;
        case (1'b1)
            up_state[UP_RESET]: begin
                // leave reset only once the pooling side is out of it too
                up_state_nx[dn_state[DN_RESET] ? UP_RESET : UP_READY] = 1'b1;
            end
            up_state[UP_READY]: begin
                up_state_nx[(image_val && image_last) ? UP_DONE : UP_READY] = 1'b1;
            end
            up_state[UP_DONE]: begin
                up_state_nx[mac_chain[MAC_LAT-1] ? UP_CLEAR : UP_DONE] = 1'b1;
            end
            up_state[UP_CLEAR]: begin
                up_state_nx[dn_state[DN_READY] ? UP_RESET : UP_CLEAR] = 1'b1;
            end
            default: begin
                up_state_nx[UP_RESET] = 1'b1;
            end
        endcase
    end

    // pool and post-ops side
    always_comb begin
        dn_state_nx = '0;
        case (1'b1)
            dn_state[DN_RESET]: begin
                dn_state_nx[DN_READY] = 1'b1;
            end
            dn_state[DN_READY]: begin
                dn_state_nx[up_state[UP_CLEAR] ? DN_ADD : DN_READY] = 1'b1;
            end
            dn_state[DN_ADD]: begin
                dn_state_nx[DN_POOL] = 1'b1;
            end
            dn_state[DN_POOL]: begin
                dn_state_nx[pool_full ? DN_OPS : DN_READY] = 1'b1;
            end
            dn_state[DN_OPS]: begin
                dn_state_nx[ops_chain[OPS_LAT-1] ? DN_CLEAR : DN_OPS] = 1'b1;
            end
            dn_state[DN_CLEAR]: begin
                dn_state_nx[result_rdy ? DN_RESET : DN_CLEAR] = 1'b1;
            end
            default: begin
                dn_state_nx[DN_RESET] = 1'b1;
            end
        endcase
    end

    // single pulses march down the valid delay chains towards the end state
    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_rdy <= 1'b0;
            prod_val   <= 1'b0;
            mac_chain  <= '0;
            ops_chain  <= '0;
        end else begin
            kernel_rdy <= image_acc;
            prod_val   <= kernel_rdy;
            mac_chain  <= (mac_chain << 1) | MAC_LAT'(image_acc & image_last);
            ops_chain  <= (ops_chain << 1) | OPS_LAT'(dn_state[DN_POOL] & pool_full);
        end
    end

    // frames folded into the current window
    always_ff @(posedge clk) begin
        if (rst || dn_state[DN_RESET]) begin
            pool_cnt <= '0;
        end else if (dn_state[DN_POOL]) begin
            pool_cnt <= pool_cnt + 1'b1;
        end
    end

    assign image_rdy  = up_state[UP_READY];
    assign result_val = dn_state[DN_CLEAR];

    assign lane_ctrl.acc_clear    = up_state[UP_RESET];
    assign lane_ctrl.acc_en       = prod_val;
    assign lane_ctrl.hold_en      = up_state[UP_CLEAR] & dn_state[DN_READY];
    assign lane_ctrl.pool_restart = dn_state[DN_POOL] & (pool_cnt == '0);
    assign lane_ctrl.pool_en      = dn_state[DN_POOL];
    assign lane_ctrl.ops_en       = dn_state[DN_OPS];
    assign lane_ctrl.result_load  = ops_chain[OPS_LAT-1];

endmodule

// File: src/layers_top.sv
`timescale 1ns/1ns

`include "layers_cfg.svh"

module layers_top
    import layers_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cfg_write_t  cfg,
    input  image_beat_t image,
    input  logic        image_val,
    output logic        image_rdy,
    input  kernel_bus_t kernel_bus,
    output logic        kernel_rdy,
    input  bias_bus_t   bias_bus,
    output result_t     result_bus,
    output logic        result_val,
    input  logic        result_rdy
);

    layer_cfg_t layer_cfg;
    lane_ctrl_t lane_ctrl;

    layer_cfg_regs layer_cfg_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .layer_cfg (layer_cfg)
    );

    layers_ctrl layers_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .layer_cfg  (layer_cfg),
        .image_val  (image_val),
        .image_last (image.last),
        .image_rdy  (image_rdy),
        .kernel_rdy (kernel_rdy),
        .result_val (result_val),
        .result_rdy (result_rdy),
        .lane_ctrl  (lane_ctrl)
    );

    // one conv and post-ops pair per depth lane
    for (genvar d = 0; d < `LAYERS_DEPTH_NB; d++) begin : g_lane
        num_t frame_sum;

        conv_lane conv_lane_inst (
            .clk       (clk),
            .lane_ctrl (lane_ctrl),
            .pixels    (image),
            .kernels   (kernel_bus[d]),
            .frame_sum (frame_sum)
        );

        post_ops_lane post_ops_lane_inst (
            .clk       (clk),
            .lane_ctrl (lane_ctrl),
            .layer_cfg (layer_cfg),
            .frame_sum (frame_sum),
            .bias      (bias_bus[d]),
            .result    (result_bus[d])
        );
    end

endmodule

// File: bench/layers_tb.sv
`timescale 1ns/1ns

`include "layers_cfg.svh"

module layers_tb
    import layers_pkg::*;
();

    localparam int TIMEOUT = 500;

    logic        clk;
    logic        rst;
    cfg_write_t  cfg;
    image_beat_t image;
    logic        image_val;
    logic        image_rdy;
    kernel_bus_t kernel_bus;
    logic        kernel_rdy;
    bias_bus_t   bias_bus;
    result_t     result_bus;
    logic        result_val;
    logic        result_rdy;

    integer      seed;
    int          stall_max;
    int          stall_left;
    kernel_bus_t pending_ker;
    result_t     exp_q[$];
    logic        held_val;
    result_t     held_bus;
    logic        prev_hs;

    layers_top layers_top_inst (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .image      (image),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .kernel_bus (kernel_bus),
        .kernel_rdy (kernel_rdy),
        .bias_bus   (bias_bus),
        .result_bus (result_bus),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH at %0t ns: %s, got %b expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic check_result(input result_t got, input result_t exp, input string what);
        for (int d = 0; d < `LAYERS_DEPTH_NB; d++) begin
            if (got[d] !== exp[d]) begin
                fail_now($sformatf("MISMATCH at %0t ns: %s, lane %0d got %0d expected %0d",
                    $time, what, d, got[d], exp[d]));
            end
        end
    endtask

    task automatic read_int(input int fd, output int val);
        int code;
        code = $fscanf(fd, "%d", val);
        if (code != 1) begin
            fail_now("The stimulus file ended inside a record or held a bad number");
        end
    endtask

    // steps one cycle from falling edge to falling edge and watches both ports
    task automatic advance;
        logic acc;
        logic hs;
        acc = image_val && image_rdy;
        hs  = result_val && result_rdy;
        if (prev_hs) begin
            check_flag(result_val, 1'b0, "result_val one cycle after a handshake");
        end
        if (held_val) begin
            check_flag(result_val, 1'b1, "result_val dropped while stalled");
            check_result(result_bus, held_bus, "result_bus moved while stalled");
        end
        if (hs) begin
            if (exp_q.size() == 0) begin
                fail_now("A result came out with no expected value left to compare");
            end
            check_result(result_bus, exp_q.pop_front(), "result in frame order");
        end
        held_val = result_val && !result_rdy;
        held_bus = result_bus;
        prev_hs  = hs;
        @(negedge clk);
        check_flag(kernel_rdy, acc, "kernel_rdy in the cycle after an accepted beat");
        // kernels go out in the cycle where kernel_rdy is high
        if (acc) begin
            kernel_bus = pending_ker;
        end
        if (stall_left > 0) begin
            result_rdy = 1'b0;
            stall_left--;
        end else begin
            result_rdy = 1'b1;
            stall_left = $unsigned($random(seed)) % (stall_max + 1);
        end
    endtask

    task automatic send_beat(input image_beat_t beat, input kernel_bus_t kers);
        int gap;
        int waited;
        gap = (stall_max > 0) ? $unsigned($random(seed)) % (stall_max + 1) : 0;
        repeat (gap) advance();
        image       = beat;
        image_val   = 1'b1;
        pending_ker = kers;
        waited      = 0;
        while (!image_rdy) begin
            advance();
            waited++;
            if (waited > TIMEOUT) begin
                fail_now("Timed out waiting for image_rdy with a beat on the port");
            end
        end
        advance();
        image_val = 1'b0;
    endtask

    // nothing may be in flight when settings or biases change
    task automatic drain_results;
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            advance();
            waited++;
            if (waited > TIMEOUT) begin
                fail_now("Timed out waiting for the outstanding results to come out");
            end
        end
        repeat (2) advance();
    endtask

    task automatic write_config(input logic [`LAYERS_CFG_DWIDTH-1:0] data);
        cfg.valid = 1'b1;
        cfg.addr  = `LAYERS_CFG_AWIDTH'(`LAYERS_CFG_ADDR);
        cfg.data  = data;
        advance();
        cfg.valid = 1'b0;
    endtask

    initial begin
        int                           fd;
        int                           code;
        int                           nbeats;
        int                           val;
        logic [7:0]                   tag;
        logic [8*200-1:0]             line;
        logic [`LAYERS_CFG_DWIDTH-1:0] word;
        image_beat_t                  beat;
        kernel_bus_t                  kers;
        bias_bus_t                    bias;
        result_t                      expv;

        seed         = 32'hfc436027;
        stall_max    = 0;
        stall_left   = 0;
        rst          = 1'b1;
        cfg          = '0;
        image        = '0;
        image_val    = 1'b0;
        kernel_bus   = '0;
        bias_bus     = '0;
        result_rdy   = 1'b0;
        pending_ker  = '0;
        held_val     = 1'b0;
        held_bus     = '0;
        prev_hs      = 1'b0;

        fd = $fopen("bench/layers_stim.txt", "r");
        if (fd == 0) begin
            fail_now("Could not open the stimulus file bench/layers_stim.txt");
        end

        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_flag(image_rdy, 1'b0, "image_rdy in reset");
            check_flag(kernel_rdy, 1'b0, "kernel_rdy in reset");
            check_flag(result_val, 1'b0, "result_val in reset");
        end
        rst = 1'b0;

        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code == 1) begin
                case (tag)
                    "#": code = $fgets(line, fd);
                    "C": begin
                        code = $fscanf(fd, "%h", word);
                        if (code != 1) begin
                            fail_now("A config record in the stimulus file has no word");
                        end
                        drain_results();
                        write_config(word);
                    end
                    "B": begin
                        for (int d = 0; d < `LAYERS_DEPTH_NB; d++) begin
                            read_int(fd, val);
                            bias[d] = ker_t'(val);
                        end
                        drain_results();
                        bias_bus = bias;
                    end
                    "S": read_int(fd, stall_max);
                    "F": begin
                        read_int(fd, nbeats);
                        for (int b = 0; b < nbeats; b++) begin
                            for (int g = 0; g < `LAYERS_GROUP_NB; g++) begin
                                read_int(fd, val);
                                beat.pix[g] = pixel_t'(val);
                            end
                            read_int(fd, val);
                            beat.last = 1'(val);
                            for (int d = 0; d < `LAYERS_DEPTH_NB; d++) begin
                                for (int g = 0; g < `LAYERS_GROUP_NB; g++) begin
                                    read_int(fd, val);
                                    kers[d][g] = ker_t'(val);
                                end
                            end
                            send_beat(beat, kers);
                        end
                    end
                    "E": begin
                        for (int d = 0; d < `LAYERS_DEPTH_NB; d++) begin
                            read_int(fd, val);
                            expv[d] = pixel_t'(val);
                        end
                        exp_q.push_back(expv);
                    end
                    default: fail_now("The stimulus file holds an unknown record type");
                endcase
            end
        end
        $fclose(fd);
        drain_results();

        if (!result_val) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_now("A result is still waiting on the port after the last expected one");
        end
    end

endmodule

// File: sources.f
+incdir+include
src/layers_pkg.sv
src/layer_cfg_regs.sv
src/conv_lane.sv
src/post_ops_lane.sv
src/layers_ctrl.sv
src/layers_top.sv
bench/layers_tb.sv

// File: bench/layers_stim.txt
# C cfg word (hex), B bias per lane, S max stall cycles, E expected result per lane
# F n then n beats: pix0 pix1 last  k0.0 k0.1  k1.0 k1.1  k2.0 k2.1  k3.0 k3.1
C 00000000
B 10 -20 0 5
S 0
F 2
3 -2 0      1 1   2 0   -1 4   0 3
5 7 1       2 -1  1 1   0 0    -3 2
E 14 0 0 0
F 1
100 -50 1   1 1   1 -1   -2 0   3 2
E 60 130 0 205
C 00010000
F 1
100 -50 1   1 1   1 -1   -2 0   3 2
E 60 130 -200 205
C 00000200
B 0 -100 7 0
F 1
10 20 1     1 1   -1 0   2 -1   0 1
F 1
40 -5 1     1 1   -1 0   2 -1   0 1
F 1
-7 9 1      1 1   -1 0   2 -1   0 1
E 35 0 92 20
C 00010004
B 3 -3 0 0
F 1
30000 1000 1   1 1   -1 0   20 0   -20 0
E 1937 -1876 32767 -32768
C 00000000
B 1 2 3 4
S 3
F 1
5 6 1       1 0   0 1   1 1   2 0
E 6 8 14 14
F 1
7 8 1       1 0   0 1   1 1   2 0
E 8 10 18 18
F 1
9 1 1       1 0   0 1   1 1   2 0
E 10 3 13 22
F 1
2 3 1       1 0   0 1   1 1   2 0
E 3 5 8 8
F 2
4 -1 0      1 0   0 1   1 1   2 0
-3 2 1      1 0   0 1   1 1   2 0
E 2 3 5 6
